/* list.f */
rtl/bf16_pkg.sv
rtl/int_type_pkg.sv
rtl/bf16_clz64.sv
rtl/bf16_cmd_decode.sv
rtl/bf16_cast_execute.sv
rtl/bf16_result_port.sv
rtl/bf16_cast_unit.sv
sim/tb_bf16_cast_unit.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_bf16_cast_unit
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Finished with no errors
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then echo "simulation passed"; \
	else echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_bf16_cast_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_bf16_cast_unit import int_type_pkg::*, bf16_pkg::*;
();

	localparam int clk_period = 40;
	localparam int drive_dly = 2;
	localparam int wait_limit = 200;

	logic clk = 1'b0;
	logic rst_n;
	logic cmd_req;
	cast_cmd_t cmd;
	logic cmd_ack;
	logic res_req;
	cast_res_t res;
	logic res_ack;

	int seed = 32'h3498_aea3;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int in_flight = 0;
	int peak_in_flight = 0;
	logic stalled = 1'b0;
	logic cmd_ack_q;
	logic res_ack_q;
	string test_name = "reset";
	cast_cmd_t cmd_q[$];
	logic [63:0] exp_q[$];

	bf16_cast_unit u_dut
	(
		.clk(clk),
		.rst_n(rst_n),
		.cmd_req(cmd_req),
		.cmd(cmd),
		.cmd_ack(cmd_ack),
		.res_req(res_req),
		.res(res),
		.res_ack(res_ack)
	);

	always #(clk_period / 2) clk = ~clk;

	function automatic void note_failure(input string what);
		$display("Handshake failure in test %s: %s", test_name, what);
		errors++;
	endfunction

	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cmd_ack) |-> $past(cmd_req))
		else note_failure("cmd_ack rose without a pending cmd_req");
	assert property (@(posedge clk) disable iff (!rst_n)
		$fell(cmd_ack) |-> !$past(cmd_req))
		else note_failure("cmd_ack dropped while cmd_req was still high");
	assert property (@(posedge clk) disable iff (!rst_n)
		(res_req && $past(res_req)) |-> $stable(res))
		else note_failure("res changed while res_req was high");
	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(res_req) |-> !$past(res_ack))
		else note_failure("res_req rose while res_ack was still high");
	assert property (@(posedge clk) disable iff (!rst_n)
		$fell(res_req) |-> $past(res_ack))
		else note_failure("res_req dropped before res_ack was seen");

	// commands held inside the unit, counted from ack edges
	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			in_flight = 0;
			cmd_ack_q = 1'b0;
			res_ack_q = 1'b0;
		end
		else
		begin
			if (cmd_ack && !cmd_ack_q)
				in_flight++;
			if (!res_ack && res_ack_q)
				in_flight--;
			cmd_ack_q = cmd_ack;
			res_ack_q = res_ack;
			if (in_flight > peak_in_flight)
				peak_in_flight = in_flight;
			assert (in_flight <= 4)
			else note_failure("cmd_ack rose with four commands already in flight");
		end
	end

	function automatic int type_bits(input type_size_t sz);
		case (sz)
			sz_8: return 8;
			sz_16: return 16;
			sz_32: return 32;
			default: return 64;
		endcase
	endfunction

	// integer to bfloat16 reference, mantissa truncated
	function automatic logic [63:0] model_from_int(input cast_cmd_t c);
		int bits;
		int msb;
		int k;
		logic neg;
		logic [63:0] v;
		bf16_t f;
		bits = type_bits(c.type_size);
		v = c.operand;
		if (bits < 64)
			v = v & ((64'd1 << bits) - 64'd1);
		neg = c.is_signed && v[bits-1];
		if (neg)
			v = (bits < 64) ? (64'd1 << bits) - v : -v;
		if (v == 64'd0)
			return 64'd0;
		msb = 0;
		for (k = 0; k < 64; k++)
			if (v[k])
				msb = k;
		f.sign = neg;
		f.enc_exp = 8'(bf16_bias + msb);
		f.enc_mantissa = '0;
		for (k = 1; k <= 7 && k <= msb; k++)
			f.enc_mantissa[7 - k] = v[msb - k];
		return {48'd0, f};
	endfunction

	// bfloat16 to integer reference, toward zero with saturation
	function automatic logic [63:0] model_to_int(input cast_cmd_t c);
		bf16_t f;
		int bits;
		int p;
		logic [63:0] sig;
		logic [63:0] mag;
		logic [63:0] lim_pos;
		logic [63:0] lim_neg;
		logic over;
		f = c.operand[15:0];
		bits = type_bits(c.type_size);
		if (f.enc_exp < bf16_bias || (f.enc_exp == 8'hff && f.enc_mantissa != '0))
			return 64'd0;
		if (f.sign && !c.is_signed)
			return 64'd0;
		p = f.enc_exp - bf16_bias;
		lim_neg = 64'd1 << (bits - 1);
		lim_pos = c.is_signed ? lim_neg - 64'd1 : (lim_neg << 1) - 64'd1;
		sig = {56'd0, 1'b1, f.enc_mantissa};
		mag = (p >= 7) ? sig << (p - 7) : sig >> (7 - p);
		over = (p >= 64) || (f.sign ? mag > lim_neg : mag > lim_pos);
		if (over)
			return f.sign ? -lim_neg : lim_pos;
		return f.sign ? -mag : mag;
	endfunction

	function automatic logic [63:0] expected_of(input cast_cmd_t c);
		return (c.op == op_from_int) ? model_from_int(c) : model_to_int(c);
	endfunction

	function automatic cast_cmd_t make_cmd(input cast_op_t op, input type_size_t sz,
		input logic sgn, input logic [63:0] operand);
		cast_cmd_t c;
		c.op = op;
		c.type_size = sz;
		c.is_signed = sgn;
		c.operand = operand;
		return c;
	endfunction

	function automatic void queue_cmd(input cast_cmd_t c, input logic [63:0] want);
		cmd_q.push_back(c);
		exp_q.push_back(want);
	endfunction

	// exponents from below 1.0 to past 2^64, one in eight all ones
	function automatic logic [15:0] random_bf16();
		logic [31:0] r;
		logic [31:0] m;
		logic [7:0] e;
		r = $random(seed);
		m = $random(seed);
		e = (r[2:0] == 3'd0) ? 8'hff : 8'(118 + r[31:8] % 80);
		return {m[8], e, m[6:0]};
	endfunction

	task automatic step();
		@(posedge clk);
		#drive_dly;
	endtask

	// polls res_req or cmd_ack until it reaches level
	task automatic wait_for(input logic on_result, input logic level);
		int n;
		n = 0;
		while (!stalled && (on_result ? res_req : cmd_ack) !== level)
		begin
			step();
			n++;
			if (n > wait_limit)
			begin
				$display("Handshake stalled in test %s: %s never went to %b", test_name,
					on_result ? "res_req" : "cmd_ack", level);
				stalled = 1'b1;
			end
		end
	endtask

	task automatic drive_all(input logic hold_req);
		while (cmd_q.size() > 0 && !stalled)
		begin
			cmd = cmd_q.pop_front();
			cmd_req = 1'b1;
			wait_for(1'b0, 1'b1);
			// source may keep req up a few cycles after ack
			if (hold_req)
				repeat (cmd.operand[1:0])
					step();
			cmd_req = 1'b0;
			wait_for(1'b0, 1'b0);
		end
	endtask

	task automatic collect(input int count, input int max_hold);
		int i;
		logic [63:0] want;
		for (i = 0; i < count; i++)
		begin
			wait_for(1'b1, 1'b1);
			if (stalled)
				break;
			// sink holds off ack to back up the pipeline
			if (max_hold > 0)
				repeat (8 + {$random(seed)} % max_hold)
					step();
			want = exp_q.pop_front();
			checks++;
			assert (res === want)
			else
			begin
				$display("Error: test %s expected %h actual %h", test_name, want, res);
				errors++;
			end
			res_ack = 1'b1;
			wait_for(1'b1, 1'b0);
			// sink may keep ack up a little after req drops
			if (max_hold > 0)
				repeat ({$random(seed)} % 4)
					step();
			res_ack = 1'b0;
		end
	endtask

	task automatic run_batch(input string name, input int max_hold);
		int errs_before;
		int n;
		errs_before = errors;
		n = cmd_q.size();
		test_name = name;
		fork
			drive_all(max_hold > 0);
			collect(n, max_hold);
		join
		tests_run++;
		$display("test %s: %0d results, %0d errors", name, n, errors - errs_before);
	endtask

	initial
	begin
		int i;
		cast_cmd_t c;
		rst_n = 1'b0;
		cmd_req = 1'b0;
		cmd = '0;
		res_ack = 1'b0;
		repeat (4) @(posedge clk);
		#drive_dly;
		rst_n = 1'b1;
		step();
		checks++;
		assert (cmd_ack === 1'b0 && res_req === 1'b0)
		else
		begin
			$display("Error: test reset expected cmd_ack=0 res_req=0 actual cmd_ack=%b res_req=%b",
				cmd_ack, res_req);
			errors++;
		end

		queue_cmd(make_cmd(op_from_int, sz_32, 1'b0, 64'd0), 64'h0000);
		queue_cmd(make_cmd(op_from_int, sz_64, 1'b1, 64'd1), 64'h3f80);
		queue_cmd(make_cmd(op_from_int, sz_8, 1'b0, 64'hff), 64'h437f);
		queue_cmd(make_cmd(op_from_int, sz_8, 1'b1, 64'h80), 64'hc300);
		run_batch("known_values", 0);

		// signed 64-bit minimum
		queue_cmd(make_cmd(op_from_int, sz_64, 1'b1, 64'h8000_0000_0000_0000), 64'hdf00);
		for (i = 0; i < 60; i++)
		begin
			c = make_cmd(op_from_int, type_size_t'(2'($random(seed))), 1'($random(seed)),
				{$random(seed), $random(seed)});
			queue_cmd(c, expected_of(c));
		end
		run_batch("random_from_int", 0);

		queue_cmd(make_cmd(op_to_int, sz_32, 1'b1, 64'h7f80), 64'h0000_0000_7fff_ffff);
		queue_cmd(make_cmd(op_to_int, sz_8, 1'b1, 64'hff80), 64'hffff_ffff_ffff_ff80);
		queue_cmd(make_cmd(op_to_int, sz_64, 1'b0, 64'h7fc1), 64'd0);
		queue_cmd(make_cmd(op_to_int, sz_16, 1'b1, 64'h3f00), 64'd0);
		queue_cmd(make_cmd(op_to_int, sz_16, 1'b0, 64'hc040), 64'd0);
		queue_cmd(make_cmd(op_to_int, sz_8, 1'b1, 64'hc308), 64'hffff_ffff_ffff_ff80);
		queue_cmd(make_cmd(op_to_int, sz_8, 1'b0, 64'h437f), 64'h0000_0000_0000_00ff);
		queue_cmd(make_cmd(op_to_int, sz_64, 1'b1, 64'hc2f7), 64'hffff_ffff_ffff_ff85);
		for (i = 0; i < 60; i++)
		begin
			c = make_cmd(op_to_int, type_size_t'(2'($random(seed))), 1'($random(seed)),
				{48'd0, random_bf16()});
			queue_cmd(c, expected_of(c));
		end
		run_batch("random_to_int", 0);

		peak_in_flight = 0;
		for (i = 0; i < 24; i++)
		begin
			c = make_cmd(cast_op_t'(1'($random(seed))), type_size_t'(2'($random(seed))),
				1'($random(seed)), {$random(seed), $random(seed)});
			if (c.op == op_to_int)
				c.operand = {48'd0, random_bf16()};
			queue_cmd(c, expected_of(c));
		end
		run_batch("back_pressure", 20);
		checks++;
		assert (peak_in_flight == 4)
		else
		begin
			$display("Error: test back_pressure expected 4 in flight actual %0d",
				peak_in_flight);
			errors++;
		end

		$display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0 && !stalled)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/bf16_cast_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module bf16_cast_unit import int_type_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic cmd_req,
	input cast_cmd_t cmd,
	output logic cmd_ack,
	output logic res_req,
	output cast_res_t res,
	input logic res_ack
);

	logic dec_valid;
	logic dec_ready;
	cast_dec_t dec;
	logic exe_valid;
	logic exe_ready;
	cast_res_t exe_res;

	bf16_cmd_decode u_decode
	(
		.clk(clk),
		.rst_n(rst_n),
		.cmd_req(cmd_req),
		.cmd(cmd),
		.cmd_ack(cmd_ack),
		.dec_valid(dec_valid),
		.dec(dec),
		.dec_ready(dec_ready)
	);

	bf16_cast_execute u_execute
	(
		.clk(clk),
		.rst_n(rst_n),
		.dec_valid(dec_valid),
		.dec(dec),
		.dec_ready(dec_ready),
		.exe_valid(exe_valid),
		.exe_res(exe_res),
		.exe_ready(exe_ready)
	);

	bf16_result_port u_result
	(
		.clk(clk),
		.rst_n(rst_n),
		.exe_valid(exe_valid),
		.exe_res(exe_res),
		.exe_ready(exe_ready),
		.res_req(res_req),
		.res(res),
		.res_ack(res_ack)
	);

endmodule

`default_nettype wire

/* rtl/bf16_result_port.sv */
`timescale 1ns/10ps
`default_nettype none

module bf16_result_port import int_type_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic exe_valid,
	input cast_res_t exe_res,
	output logic exe_ready,
	output logic res_req,
	output cast_res_t res,
	input logic res_ack
);

	typedef enum logic [1:0]
	{
		st_empty,
		st_wait_ack_hi,
		st_wait_ack_lo
	} rp_state_t;

	rp_state_t state;

	assign exe_ready = (state == st_empty);
	assign res_req = (state == st_wait_ack_hi);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= st_empty;
		else
		begin
			case (state)
				st_empty:
					if (exe_valid)
						state <= st_wait_ack_hi;
				st_wait_ack_hi:
					if (res_ack)
						state <= st_wait_ack_lo;
				st_wait_ack_lo:
					// free again once the sink has released ack
					if (!res_ack)
						state <= st_empty;
				default:
					state <= st_empty;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (exe_valid && exe_ready)
			res <= exe_res;
	end

endmodule

`default_nettype wire

/* rtl/bf16_cast_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module bf16_cast_execute import int_type_pkg::*, bf16_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic dec_valid,
	input cast_dec_t dec,
	output logic dec_ready,
	output logic exe_valid,
	output cast_res_t exe_res,
	input logic exe_ready
);

	typedef enum logic
	{
		st_idle,
		st_finishing
	} s1_state_t;

	s1_state_t s1_state;
	cast_dec_t s1_dec;
	logic [6:0] s1_clz;
	logic [6:0] clz;
	logic s1_load;
	logic s1_adv;
	cast_res_t from_res;
	cast_res_t to_res;
	cast_res_t s2_res;

	bf16_clz64 u_clz64
	(
		.in(dec.magnitude),
		.count(clz)
	);

	assign s1_adv = (s1_state == st_finishing) && (!exe_valid || exe_ready);
	assign dec_ready = (s1_state == st_idle) || s1_adv;
	assign s1_load = dec_valid && dec_ready;

	// integer to bfloat16, mantissa truncated
	always_comb
	begin
		logic [63:0] norm;
		bf16_t f_out;

		norm = s1_dec.magnitude << s1_clz;
		f_out.sign = s1_dec.sign;
		f_out.enc_exp = bf16_exp_w'(bf16_bias + 63 - s1_clz);
		f_out.enc_mantissa = norm[62 -: bf16_mant_w];
		if (s1_dec.magnitude == 64'd0)
			f_out = '0;
		from_res = {48'b0, f_out};
	end

	// bfloat16 to integer, toward zero with saturation
	always_comb
	begin
		bf16_t f_in;
		logic [7:0] ue;
		logic [7:0] ty_msb;
		logic [63:0] umax;
		logic [63:0] smax;
		logic [63:0] sig;
		logic [63:0] mag;
		logic ovf;

		f_in = s1_dec.magnitude[15:0];
		ue = f_in.enc_exp - bf16_exp_w'(bf16_bias);

		case (s1_dec.type_size)
			sz_8:
			begin
				ty_msb = 8'd7;
				umax = 64'h0000_0000_0000_00ff;
			end
			sz_16:
			begin
				ty_msb = 8'd15;
				umax = 64'h0000_0000_0000_ffff;
			end
			sz_32:
			begin
				ty_msb = 8'd31;
				umax = 64'h0000_0000_ffff_ffff;
			end
			default:
			begin
				ty_msb = 8'd63;
				umax = 64'hffff_ffff_ffff_ffff;
			end
		endcase
		smax = umax >> 1;

		sig = {56'b0, 1'b1, f_in.enc_mantissa};
		if (ue >= 8'd7)
			mag = sig << (ue - 8'd7);
		else
			mag = sig >> (8'd7 - ue);

		// infinity lands here too, its unbiased exponent is 128
		ovf = s1_dec.is_signed ? (ue >= ty_msb) : (ue > ty_msb);

		if (f_in.enc_exp == 8'hff && f_in.enc_mantissa != '0)
			to_res = '0;
		else if (f_in.enc_exp < bf16_exp_w'(bf16_bias))
			to_res = '0;
		else if (f_in.sign && !s1_dec.is_signed)
			to_res = '0;
		else if (ovf)
			to_res = f_in.sign ? ~smax : (s1_dec.is_signed ? smax : umax);
		else
			to_res = f_in.sign ? (~mag + 64'd1) : mag;
	end

	assign s2_res = (s1_dec.op == op_from_int) ? from_res : to_res;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s1_state <= st_idle;
			exe_valid <= 1'b0;
		end
		else
		begin
			if (s1_load)
				s1_state <= st_finishing;
			else if (s1_adv)
				s1_state <= st_idle;

			if (s1_adv)
				exe_valid <= 1'b1;
			else if (exe_ready)
				exe_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (s1_load)
		begin
			s1_dec <= dec;
			s1_clz <= clz;
		end
		if (s1_adv)
			exe_res <= s2_res;
	end

endmodule

`default_nettype wire

/* rtl/bf16_cmd_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module bf16_cmd_decode import int_type_pkg::*, bf16_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic cmd_req,
	input cast_cmd_t cmd,
	output logic cmd_ack,
	output logic dec_valid,
	output cast_dec_t dec,
	input logic dec_ready
);

	logic capture;
	logic top_bit;
	logic neg;
	logic [63:0] narrow;
	logic [63:0] size_mask;
	bf16_t in_bf16;
	cast_dec_t next_dec;

	// new req only after the previous ack dropped and nothing is held
	assign capture = cmd_req && !cmd_ack && !dec_valid;

	assign in_bf16 = cmd.operand[15:0];

	always_comb
	begin
		case (cmd.type_size)
			sz_8: size_mask = 64'h0000_0000_0000_00ff;
			sz_16: size_mask = 64'h0000_0000_0000_ffff;
			sz_32: size_mask = 64'h0000_0000_ffff_ffff;
			default: size_mask = 64'hffff_ffff_ffff_ffff;
		endcase

		case (cmd.type_size)
			sz_8: top_bit = cmd.operand[7];
			sz_16: top_bit = cmd.operand[15];
			sz_32: top_bit = cmd.operand[31];
			default: top_bit = cmd.operand[63];
		endcase

		narrow = cmd.operand & size_mask;
		neg = cmd.is_signed && top_bit;

		next_dec.op = cmd.op;
		next_dec.type_size = cmd.type_size;
		next_dec.is_signed = cmd.is_signed;
		if (cmd.op == op_from_int)
		begin
			next_dec.sign = neg;
			// two's complement within the operand width, 64 bits included
			next_dec.magnitude = neg ? ((~narrow + 64'd1) & size_mask) : narrow;
		end
		else
		begin
			next_dec.sign = in_bf16.sign;
			next_dec.magnitude = {48'b0, in_bf16};
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cmd_ack <= 1'b0;
			dec_valid <= 1'b0;
		end
		else if (capture)
		begin
			cmd_ack <= 1'b1;
			dec_valid <= 1'b1;
		end
		else
		begin
			if (cmd_ack && !cmd_req)
				cmd_ack <= 1'b0;
			if (dec_valid && dec_ready)
				dec_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
			dec <= next_dec;
	end

endmodule

`default_nettype wire

/* rtl/bf16_clz64.sv */
`timescale 1ns/10ps
`default_nettype none

module bf16_clz64
(
	input logic [63:0] in,
	output logic [6:0] count
);

	logic found;

	// priority search from the top bit down
	always_comb
	begin
		count = 7'd64;
		found = 1'b0;
		for (int i = 63; i >= 0; i--)
		begin
			if (!found && in[i])
			begin
				count = 7'(63 - i);
				found = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/int_type_pkg.sv */
`default_nettype none

package int_type_pkg;

	// integer operand sizes of the CPU
	typedef enum logic [1:0]
	{
		sz_8,
		sz_16,
		sz_32,
		sz_64
	} type_size_t;

	typedef enum logic
	{
		op_from_int,
		op_to_int
	} cast_op_t;

	// command as seen on the input port
	typedef struct packed
	{
		cast_op_t op;
		type_size_t type_size;
		logic is_signed;
		logic [63:0] operand;
	} cast_cmd_t;

	// decoded command handed to the execute pipeline
	typedef struct packed
	{
		cast_op_t op;
		type_size_t type_size;
		logic is_signed;
		logic sign;
		logic [63:0] magnitude;
	} cast_dec_t;

	// zero or sign extended result, depending on op and type
	typedef logic [63:0] cast_res_t;

endpackage

`default_nettype wire

/* rtl/bf16_pkg.sv */
`default_nettype none

package bf16_pkg;

	// field widths of the 16-bit brain float format
	localparam int unsigned bf16_exp_w = 8;
	localparam int unsigned bf16_mant_w = 7;

	// exponent bias, same as IEEE single precision
	localparam int unsigned bf16_bias = 127;

	typedef struct packed
	{
		logic sign;
		logic [bf16_exp_w-1:0] enc_exp;
		logic [bf16_mant_w-1:0] enc_mantissa;
	} bf16_t;

endpackage

`default_nettype wire
